// ==== mpreg_settings.svh ====
// sizing for the mpreg execute cluster.
// MP_AW must equal log2 of MP_NREG and stay at 5 or below to fit the instruction word.
`ifndef MPREG_SETTINGS_SVH
`define MPREG_SETTINGS_SVH

// data width of registers and ALU lanes.
`define MP_DW 32

// register file size.
`define MP_NREG 32

// register address width.
`define MP_AW 5

// write-back queue depth in pairs, also the source credit count.
`define MP_WBQ_PAIRS 4

`endif

// ==== mpreg_pkg.sv ====
// instruction words are 32 bits whatever MP_DW is.
// opcodes 8 to 15 are unused and decode as an empty lane.
`include "mpreg_settings.svh"

package mpreg_pkg;

	typedef enum logic [3:0] {
		NOP  = 4'h0,
		ADD  = 4'h1,
		SUB  = 4'h2,
		AND  = 4'h3,
		XOR  = 4'h4,
		ADDI = 4'h5,
		LI   = 4'h6,
		ACC  = 4'h7
	} mp_op_e;

	// register form.
	typedef struct packed {
		mp_op_e opcode;
		logic [`MP_AW-1:0] rd;
		logic [`MP_AW-1:0] rs1;
		logic [`MP_AW-1:0] rs2;
		logic [32-4-3*`MP_AW-1:0] pad;
	} mp_r_form_s;

	// immediate form, imm is sign extended.
	typedef struct packed {
		mp_op_e opcode;
		logic [`MP_AW-1:0] rd;
		logic [`MP_AW-1:0] rs1;
		logic [32-4-2*`MP_AW-16-1:0] pad;
		logic [15:0] imm;
	} mp_i_form_s;

	typedef union packed {
		mp_r_form_s r;
		mp_i_form_s i;
	} mp_instr_u;

	typedef struct packed {
		logic valid;
		logic [`MP_AW-1:0] rd;
		logic [`MP_DW-1:0] data;
		logic acc;
	} mp_result_s;

endpackage

// ==== mpreg_if.sv ====
// lane-indexed operand link and pair result link.
// both are point to point inside mpreg_top.
`timescale 1ns/10ps
`include "mpreg_settings.svh"

interface mp_op_if import mpreg_pkg::*; ();
	logic valid;
	mp_op_e opc [2];
	logic [`MP_AW-1:0] rd [2];
	logic [`MP_DW-1:0] a [2];
	logic [`MP_DW-1:0] b [2];

	modport source (output valid, opc, rd, a, b);
	modport sink (input valid, opc, rd, a, b);
endinterface

interface mp_wb_if import mpreg_pkg::*; ();
	logic push;
	mp_result_s result0;
	mp_result_s result1;
	// one pulse per retired pair.
	logic credit;

	modport source (output push, result0, result1);
	modport sink (input push, result0, result1, output credit);
endinterface

// ==== mp_regfile.sv ====
// one write port, five asynchronous read ports, no write-to-read bypass.
// port 4 always reads the current write address.
`timescale 1ns/10ps
`include "mpreg_settings.svh"

module mp_regfile (
	input  logic clk4_i,
	input  logic rst_i,
	input  logic we_i,
	input  logic [`MP_AW-1:0] waddr_i,
	input  logic [`MP_DW-1:0] wdata_i,
	input  logic [`MP_AW-1:0] raddr0_i,
	input  logic [`MP_AW-1:0] raddr1_i,
	input  logic [`MP_AW-1:0] raddr2_i,
	input  logic [`MP_AW-1:0] raddr3_i,
	output logic [`MP_DW-1:0] rdata0_o,
	output logic [`MP_DW-1:0] rdata1_o,
	output logic [`MP_DW-1:0] rdata2_o,
	output logic [`MP_DW-1:0] rdata3_o,
	output logic [`MP_DW-1:0] rdata4_o
);

	logic [`MP_DW-1:0] mem [`MP_NREG];

	// whole array clears in the reset cycle.
	always_ff @(posedge clk4_i) begin
		if (rst_i) begin
			for (int i = 0; i < `MP_NREG; i++) begin
				mem[i] <= '0;
			end
		end else if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	assign rdata0_o = mem[raddr0_i];
	assign rdata1_o = mem[raddr1_i];
	assign rdata2_o = mem[raddr2_i];
	assign rdata3_o = mem[raddr3_i];

	// old destination value for accumulate.
	assign rdata4_o = mem[waddr_i];

endmodule

// ==== mp_operand_fetch.sv ====
// reads operands in the accept cycle, so the source must avoid in-flight writes.
// rs2 is still addressed for immediate forms and then ignored.
`timescale 1ns/10ps
`include "mpreg_settings.svh"

module mp_operand_fetch import mpreg_pkg::*; (
	input  logic clk4_i,
	input  logic rst_i,
	input  logic pair_valid_i,
	input  mp_instr_u instr0_i,
	input  mp_instr_u instr1_i,
	output logic [`MP_AW-1:0] raddr0_o,
	output logic [`MP_AW-1:0] raddr1_o,
	output logic [`MP_AW-1:0] raddr2_o,
	output logic [`MP_AW-1:0] raddr3_o,
	input  logic [`MP_DW-1:0] rdata0_i,
	input  logic [`MP_DW-1:0] rdata1_i,
	input  logic [`MP_DW-1:0] rdata2_i,
	input  logic [`MP_DW-1:0] rdata3_i,
	mp_op_if.source op
);

	mp_instr_u instr [2];
	logic [`MP_DW-1:0] rs1_val [2];
	logic [`MP_DW-1:0] rs2_val [2];

	function automatic logic is_imm(input mp_op_e opc);
		return (opc == ADDI) || (opc == LI);
	endfunction

	function automatic logic [`MP_DW-1:0] sext_imm(input mp_instr_u w);
		return {{(`MP_DW-16){w.i.imm[15]}}, w.i.imm};
	endfunction

	assign instr[0] = instr0_i;
	assign instr[1] = instr1_i;

	// ports 0 and 1 serve lane 0, ports 2 and 3 lane 1.
	assign raddr0_o = instr0_i.r.rs1;
	assign raddr1_o = instr0_i.r.rs2;
	assign raddr2_o = instr1_i.r.rs1;
	assign raddr3_o = instr1_i.r.rs2;

	assign rs1_val[0] = rdata0_i;
	assign rs2_val[0] = rdata1_i;
	assign rs1_val[1] = rdata2_i;
	assign rs2_val[1] = rdata3_i;

	always_ff @(posedge clk4_i) begin
		if (rst_i) begin
			op.valid <= 1'b0;
		end else begin
			op.valid <= pair_valid_i;
		end
	end

	always_ff @(posedge clk4_i) begin
		if (pair_valid_i) begin
			for (int l = 0; l < 2; l++) begin
				op.opc[l] <= instr[l].r.opcode;
				op.rd[l] <= instr[l].r.rd;
				if (is_imm(instr[l].i.opcode)) begin
					// li adds its immediate to zero.
					op.a[l] <= (instr[l].i.opcode == LI) ? '0 : rs1_val[l];
					op.b[l] <= sext_imm(instr[l]);
				end else begin
					op.a[l] <= rs1_val[l];
					op.b[l] <= rs2_val[l];
				end
			end
		end
	end

endmodule

// ==== mp_exec_lanes.sv ====
// two identical single-cycle ALU lanes.
// unknown opcodes give an empty lane, like NOP.
`timescale 1ns/10ps
`include "mpreg_settings.svh"

module mp_exec_lanes import mpreg_pkg::*; (
	input  logic clk4_i,
	input  logic rst_i,
	mp_op_if.sink op,
	mp_wb_if.source wb
);

	function automatic mp_result_s lane_alu(
		input mp_op_e opc,
		input logic [`MP_AW-1:0] rd,
		input logic [`MP_DW-1:0] a,
		input logic [`MP_DW-1:0] b
	);
		mp_result_s r;
		r.valid = 1'b1;
		r.rd = rd;
		r.acc = 1'b0;
		r.data = '0;
		case (opc)
			ADD, ADDI, LI: r.data = a + b;
			SUB: r.data = a - b;
			AND: r.data = a & b;
			XOR: r.data = a ^ b;
			ACC: begin
				// old destination is added in the queue.
				r.data = a;
				r.acc = 1'b1;
			end
			default: r.valid = 1'b0;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk4_i) begin
		if (rst_i) begin
			wb.push <= 1'b0;
		end else begin
			wb.push <= op.valid;
		end
	end

	always_ff @(posedge clk4_i) begin
		if (op.valid) begin
			wb.result0 <= lane_alu(op.opc[0], op.rd[0], op.a[0], op.b[0]);
			wb.result1 <= lane_alu(op.opc[1], op.rd[1], op.a[1], op.b[1]);
		end
	end

endmodule

// ==== mp_wb_queue.sv ====
// has no full check, the source credits keep push below MP_WBQ_PAIRS pairs.
// an empty pair idles one cycle at the head before it pops.
`timescale 1ns/10ps
`include "mpreg_settings.svh"

module mp_wb_queue import mpreg_pkg::*; (
	input  logic clk4_i,
	input  logic rst_i,
	mp_wb_if.sink wb,
	output logic we_o,
	output logic [`MP_AW-1:0] waddr_o,
	output logic [`MP_DW-1:0] wdata_o,
	input  logic [`MP_DW-1:0] old_i
);

	localparam int PW = (`MP_WBQ_PAIRS > 1) ? $clog2(`MP_WBQ_PAIRS) : 1;
	localparam int CW = $clog2(`MP_WBQ_PAIRS + 1);

	mp_result_s q0 [`MP_WBQ_PAIRS];
	mp_result_s q1 [`MP_WBQ_PAIRS];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic lane_ptr;
	logic head_valid;
	logic sel1;
	logic last;
	logic pop;
	mp_result_s cur;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		return (p == PW'(`MP_WBQ_PAIRS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head_valid = (count != '0);

	// lane 1 once lane 0 is done or empty.
	assign sel1 = lane_ptr || !q0[rd_ptr].valid;
	assign cur = sel1 ? q1[rd_ptr] : q0[rd_ptr];

	always_comb begin
		if (lane_ptr) begin
			last = 1'b1;
		end else if (q0[rd_ptr].valid) begin
			last = !q1[rd_ptr].valid;
		end else begin
			last = q1[rd_ptr].valid;
		end
	end

	assign pop = head_valid && last;
	assign wb.credit = pop;

	// write port, accumulate adds the value now at rd.
	assign we_o = head_valid && cur.valid;
	assign waddr_o = cur.rd;
	assign wdata_o = cur.acc ? cur.data + old_i : cur.data;

	always_ff @(posedge clk4_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			lane_ptr <= 1'b0;
		end else begin
			if (wb.push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
				lane_ptr <= 1'b0;
			end else if (head_valid) begin
				lane_ptr <= 1'b1;
			end
			count <= count + CW'(wb.push) - CW'(pop);
		end
	end

	always_ff @(posedge clk4_i) begin
		if (wb.push) begin
			q0[wr_ptr] <= wb.result0;
			q1[wr_ptr] <= wb.result1;
		end
	end

endmodule

// ==== mpreg_top.sv ====
// dual-issue execute cluster, no hazard checks.
// the source holds MP_WBQ_PAIRS credits after reset and spends one per pair.
`timescale 1ns/10ps
`include "mpreg_settings.svh"

module mpreg_top (
	input  logic clk4_i,
	input  logic rst_i,
	input  logic pair_valid_i,
	input  logic [31:0] instr0_i,
	input  logic [31:0] instr1_i,
	output logic credit_o,
	output logic wb_valid_o,
	output logic [`MP_AW-1:0] wb_addr_o,
	output logic [`MP_DW-1:0] wb_data_o
);

	logic [`MP_AW-1:0] raddr [4];
	logic [`MP_DW-1:0] rdata [4];
	logic [`MP_DW-1:0] old_data;

	mp_op_if op_if ();
	mp_wb_if wb_if ();

	mp_operand_fetch mp_operand_fetch_i (
		.clk4_i       (clk4_i),
		.rst_i        (rst_i),
		.pair_valid_i (pair_valid_i),
		.instr0_i     (instr0_i),
		.instr1_i     (instr1_i),
		.raddr0_o     (raddr[0]),
		.raddr1_o     (raddr[1]),
		.raddr2_o     (raddr[2]),
		.raddr3_o     (raddr[3]),
		.rdata0_i     (rdata[0]),
		.rdata1_i     (rdata[1]),
		.rdata2_i     (rdata[2]),
		.rdata3_i     (rdata[3]),
		.op           (op_if.source)
	);

	mp_exec_lanes mp_exec_lanes_i (
		.clk4_i (clk4_i),
		.rst_i  (rst_i),
		.op     (op_if.sink),
		.wb     (wb_if.source)
	);

	// write-back outputs show the write port directly.
	mp_wb_queue mp_wb_queue_i (
		.clk4_i  (clk4_i),
		.rst_i   (rst_i),
		.wb      (wb_if.sink),
		.we_o    (wb_valid_o),
		.waddr_o (wb_addr_o),
		.wdata_o (wb_data_o),
		.old_i   (old_data)
	);

	mp_regfile mp_regfile_i (
		.clk4_i   (clk4_i),
		.rst_i    (rst_i),
		.we_i     (wb_valid_o),
		.waddr_i  (wb_addr_o),
		.wdata_i  (wb_data_o),
		.raddr0_i (raddr[0]),
		.raddr1_i (raddr[1]),
		.raddr2_i (raddr[2]),
		.raddr3_i (raddr[3]),
		.rdata0_o (rdata[0]),
		.rdata1_o (rdata[1]),
		.rdata2_o (rdata[2]),
		.rdata3_o (rdata[3]),
		.rdata4_o (old_data)
	);

	assign credit_o = wb_if.credit;

endmodule

// ==== mpreg_top_sva.sv ====
// bound into mp_wb_queue, relies on its internal count, pop and head_valid.
`timescale 1ns/10ps
`include "mpreg_settings.svh"

module mpreg_top_sva (
	input logic clk4_i,
	input logic rst_i,
	input logic [$clog2(`MP_WBQ_PAIRS+1)-1:0] count_i,
	input logic push_i,
	input logic head_valid_i,
	input logic we_i,
	input logic pop_i,
	input logic credit_i
);

	a_occupancy: assert property (@(posedge clk4_i) disable iff (rst_i)
		count_i <= `MP_WBQ_PAIRS)
		else $error("write-back queue holds more pairs than its depth");

	// credits keep the queue from filling while pairs are in flight.
	a_no_push_full: assert property (@(posedge clk4_i) disable iff (rst_i)
		!(push_i && count_i == `MP_WBQ_PAIRS))
		else $error("push into a full write-back queue");

	// a head pair retires within two cycles, empty lanes included.
	a_head_retires: assert property (@(posedge clk4_i) disable iff (rst_i)
		head_valid_i && !pop_i |=> pop_i)
		else $error("head pair did not retire on its second cycle");

	// queue entries are not cleared by reset.
	a_outputs_known: assert property (@(posedge clk4_i) disable iff (rst_i)
		!$isunknown({we_i, credit_i}))
		else $error("write enable or credit is unknown");

endmodule

bind mp_wb_queue mpreg_top_sva mpreg_top_sva_i (
	.clk4_i       (clk4_i),
	.rst_i        (rst_i),
	.count_i      (count),
	.push_i       (wb.push),
	.head_valid_i (head_valid),
	.we_i         (we_o),
	.pop_i        (pop),
	.credit_i     (wb.credit)
);

// ==== tb_mpreg_top.sv ====
// stimulus comes from mpreg_stimulus.hex in the run directory, three words per record.
// expect records compare the register file and are only valid right after a barrier.
`timescale 1ns/10ps
`include "mpreg_settings.svh"

module tb_mpreg_top import mpreg_pkg::*; ();

	logic clk4_i;
	logic rst_i;
	logic pair_valid_i;
	logic [31:0] instr0_i;
	logic [31:0] instr1_i;
	logic credit_o;
	logic wb_valid_o;
	logic [`MP_AW-1:0] wb_addr_o;
	logic [`MP_DW-1:0] wb_data_o;

	logic [31:0] stim [0:511];
	logic [`MP_DW-1:0] ref_rf [`MP_NREG];
	mp_result_s exp_q [$];
	int credits;
	int nrec;
	int cycle_count = 0;
	int cycle_limit = 100;
	integer seed;

	mpreg_top mpreg_top_i (
		.clk4_i       (clk4_i),
		.rst_i        (rst_i),
		.pair_valid_i (pair_valid_i),
		.instr0_i     (instr0_i),
		.instr1_i     (instr1_i),
		.credit_o     (credit_o),
		.wb_valid_o   (wb_valid_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o)
	);

	initial begin
		clk4_i = 1'b0;
		forever #2 clk4_i = ~clk4_i;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk4_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			report_failure($sformatf("timeout, run passed its limit of %0d cycles", cycle_limit));
		end
	end

	task automatic check_addr(input string name, input logic [`MP_AW-1:0] got,
		input logic [`MP_AW-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_data(input string name, input logic [`MP_DW-1:0] got,
		input logic [`MP_DW-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// reference model, runs a whole pair when it is sent.
	task automatic predict_pair(input mp_instr_u w0, input mp_instr_u w1);
		mp_instr_u ins [2];
		logic [`MP_DW-1:0] a [2];
		logic [`MP_DW-1:0] b [2];
		logic [`MP_DW-1:0] imm_x;
		mp_result_s e;
		ins[0] = w0;
		ins[1] = w1;
		// both lanes read the state from before the pair.
		for (int l = 0; l < 2; l++) begin
			a[l] = ref_rf[ins[l].r.rs1];
			b[l] = ref_rf[ins[l].r.rs2];
		end
		for (int l = 0; l < 2; l++) begin
			imm_x = $signed(ins[l].i.imm);
			e.valid = 1'b1;
			e.acc = 1'b0;
			e.rd = ins[l].r.rd;
			e.data = '0;
			case (ins[l].r.opcode)
				ADD: e.data = a[l] + b[l];
				SUB: e.data = a[l] - b[l];
				AND: e.data = a[l] & b[l];
				XOR: e.data = a[l] ^ b[l];
				ADDI: e.data = a[l] + imm_x;
				LI: e.data = imm_x;
				// old value is taken at write time, so lane 0 is seen.
				ACC: e.data = ref_rf[ins[l].r.rd] + a[l];
				default: e.valid = 1'b0;
			endcase
			if (e.valid) begin
				ref_rf[e.rd] = e.data;
				exp_q.push_back(e);
			end
		end
	endtask

	task automatic observe();
		mp_result_s e;
		if ($isunknown({wb_valid_o, credit_o})) begin
			report_failure("write-back valid or credit output is unknown");
		end
		if (wb_valid_o) begin
			if (exp_q.size() == 0) begin
				report_failure("write-back seen while no write was pending");
			end
			e = exp_q.pop_front();
			check_addr("wb_addr_o", wb_addr_o, e.rd);
			check_data("wb_data_o", wb_data_o, e.data);
		end
		if (credit_o) begin
			if (credits >= `MP_WBQ_PAIRS) begin
				report_failure("credit returned with no pair outstanding");
			end
			credits++;
		end
	endtask

	// outputs are sampled before this edge takes effect.
	task automatic tick();
		@(posedge clk4_i);
		observe();
		pair_valid_i <= 1'b0;
	endtask

	task automatic send_pair(input logic [31:0] w0, input logic [31:0] w1);
		tick();
		while (credits == 0) begin
			tick();
		end
		pair_valid_i <= 1'b1;
		instr0_i <= w0;
		instr1_i <= w1;
		credits--;
		predict_pair(w0, w1);
	endtask

	task automatic wait_barrier();
		while (credits != `MP_WBQ_PAIRS) begin
			tick();
		end
		if (exp_q.size() != 0) begin
			report_failure("all credits back but write-backs are still missing");
		end
	endtask

	task automatic idle_gap(input logic [31:0] max_cycles);
		int n;
		n = $unsigned($random(seed)) % (max_cycles + 1);
		repeat (n) tick();
	endtask

	task automatic check_register(input logic [31:0] addr, input logic [31:0] value);
		logic [`MP_AW-1:0] a;
		// the last write of the barrier lands after its edge.
		@(negedge clk4_i);
		a = addr[`MP_AW-1:0];
		check_data($sformatf("regfile[%0d]", a), mpreg_top_i.mp_regfile_i.mem[a], value);
		check_data($sformatf("model r%0d", a), ref_rf[a], value);
	endtask

	task automatic count_records(output int n);
		int idx;
		n = 1;
		idx = 0;
		while (idx < 510 && stim[idx] !== 32'h0) begin
			if ($isunknown(stim[idx])) begin
				report_failure("stimulus file is short or has a bad record tag");
			end
			n++;
			idx += 3;
		end
		if (idx >= 510) begin
			report_failure("stimulus file has no end record");
		end
	endtask

	initial begin
		int idx;
		logic [31:0] tag;
		bit done;
		rst_i = 1'b1;
		pair_valid_i = 1'b0;
		instr0_i = '0;
		instr1_i = '0;
		seed = 18;
		credits = `MP_WBQ_PAIRS;
		for (int i = 0; i < `MP_NREG; i++) begin
			ref_rf[i] = '0;
		end
		$readmemh("mpreg_stimulus.hex", stim);
		count_records(nrec);
		cycle_limit = nrec * 20 + 100;
		repeat (4) @(posedge clk4_i);
		rst_i <= 1'b0;
		// quiet outputs after reset.
		repeat (3) begin
			tick();
			check_flag("wb_valid_o", wb_valid_o, 1'b0);
			check_flag("credit_o", credit_o, 1'b0);
		end
		idx = 0;
		done = 1'b0;
		while (!done) begin
			tag = stim[idx];
			case (tag)
				32'h0: done = 1'b1;
				32'h1: send_pair(stim[idx + 1], stim[idx + 2]);
				32'h2: wait_barrier();
				32'h3: idle_gap(stim[idx + 1]);
				32'h4: check_register(stim[idx + 1], stim[idx + 2]);
				default: report_failure("unknown record tag in stimulus file");
			endcase
			idx += 3;
		end
		wait_barrier();
		// stray writes or credits after the last pair.
		repeat (2 * `MP_WBQ_PAIRS) begin
			tick();
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== mpreg_stimulus.hex ====
// tag word0 word1: 1 pair (instr0 instr1), 2 barrier, 3 idle gap (max cycles)
// 4 expect (register, value), 0 end. unused words are zero.
00000001 10800000 00000000
00000001 61000005 6180FFFE
00000002 00000000 00000000
00000004 00000001 00000000
00000001 52080010 528C8000
00000002 00000000 00000000
00000003 00000005 00000000
00000001 13088000 23886000
00000001 340CA000 4490A000
00000001 00000000 25144000
00000001 45884000 00000000
00000001 00000000 00000000
00000002 00000000 00000000
00000004 00000009 FFFF7FEB
00000001 73080000 741C0000
00000002 00000000 00000000
00000001 76180000 00000000
00000001 73080000 73080000
00000002 00000000 00000000
00000004 00000006 00000029
00000001 66800011 67000022
00000001 67800033 68000044
00000001 68800055 69000066
00000001 69800077 6A000088
00000001 6A800099 6B0000AA
00000001 6B8000BB 6C0080CC
00000003 00000007 00000000
00000001 00000000 00000000
00000001 13088000 52080010
00000001 00000000 00000000
00000002 00000000 00000000
00000004 00000018 FFFF80CC
00000000 00000000 00000000

// ==== mpreg.f ====
+incdir+.
mpreg_pkg.sv
mpreg_if.sv
mp_regfile.sv
mp_operand_fetch.sv
mp_exec_lanes.sv
mp_wb_queue.sv
mpreg_top.sv
mpreg_top_sva.sv
tb_mpreg_top.sv
